// ==== ooo_defines.svh ====
////////////////////////////////////////
// out-of-order back end sizes
// dispatch/commit width, rob depth,
// data width and register count
////////////////////////////////////////

`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// instructions dispatched and committed per cycle
`define WAYS 2

// reorder buffer entries, power of two
`define ROB_DEPTH 8

// data and pc width
`define XLEN 32

// architectural registers, r0 hardwired to zero
`define NUM_REGS 32

`endif

// ==== ooo_pkg.sv ====
////////////////////////////////////////
// back end types
// vector widths and the packets passed
// between dispatch, cdb and commit
////////////////////////////////////////

`include "ooo_defines.svh"

package ooo_pkg;

	// plain vectors
	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;
	// free count spans 0..ROB_DEPTH
	typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] arch_reg_t;
	// retired per cycle, 0..WAYS
	typedef logic [$clog2(`WAYS):0] commit_cnt_t;

	// one dispatch lane
	typedef struct packed {
		logic      valid;
		arch_reg_t dest;
		logic      reg_write;
		word_t     pc;
	} dispatch_t;

	// alu result, load result and bus lane
	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
		word_t    data;
	} cdb_t;

	// one retiring rob entry
	typedef struct packed {
		logic      valid;
		arch_reg_t dest;
		logic      reg_write;
		word_t     pc;
		word_t     data;
	} commit_t;

endpackage

// ==== cdb_merge.sv ====
////////////////////////////////////////
// common data bus merge
// registers alu results onto the bus,
// load queue wins the last lane, the
// displaced alu result waits in a hold reg
////////////////////////////////////////

`timescale 1ns/1ps

`include "ooo_defines.svh"

module cdb_merge
	import ooo_pkg::*;
(
	input  logic clock,
	input  logic rst_n,
	input  cdb_t alu_result [`WAYS],
	input  cdb_t load_result,
	output cdb_t cdb [`WAYS],
	output logic alu_busy [`WAYS]
);

	localparam int LAST = `WAYS - 1;

	// bus registers, valid split from payload
	logic [`WAYS-1:0] bus_valid;
	rob_idx_t         bus_idx [`WAYS];
	word_t            bus_data [`WAYS];

	// one-entry hold for the last alu way
	logic     hold_valid;
	rob_idx_t hold_idx;
	word_t    hold_data;

	// last lane arbitration
	cdb_t last_sel;
	logic hold_load;
	logic hold_clear;

	////////////////////////////////////////
	// last lane select
	////////////////////////////////////////

	always_comb begin
		last_sel   = alu_result[LAST];
		hold_load  = 1'b0;
		hold_clear = 1'b0;
		if (load_result.valid) begin
			last_sel  = load_result;
			// alu result bumped, park it
			hold_load = alu_result[LAST].valid & ~hold_valid;
		end else if (hold_valid) begin
			// bus free again, drain the held result
			last_sel   = '{valid: 1'b1, rob_idx: hold_idx, data: hold_data};
			hold_clear = 1'b1;
		end
	end

	////////////////////////////////////////
	// control state
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			bus_valid  <= '0;
			hold_valid <= 1'b0;
		end else begin
			for (int i = 0; i < LAST; i++) begin
				bus_valid[i] <= alu_result[i].valid;
			end
			bus_valid[LAST] <= last_sel.valid;
			if (hold_load) begin
				hold_valid <= 1'b1;
			end else if (hold_clear) begin
				hold_valid <= 1'b0;
			end
		end
	end

	// payload, qualified by the valid bits above
	always_ff @(posedge clock) begin
		for (int i = 0; i < LAST; i++) begin
			bus_idx[i]  <= alu_result[i].rob_idx;
			bus_data[i] <= alu_result[i].data;
		end
		bus_idx[LAST]  <= last_sel.rob_idx;
		bus_data[LAST] <= last_sel.data;
		if (hold_load) begin
			hold_idx  <= alu_result[LAST].rob_idx;
			hold_data <= alu_result[LAST].data;
		end
	end

	// outputs
	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			cdb[i] = '{valid: bus_valid[i], rob_idx: bus_idx[i], data: bus_data[i]};
			// only the last way can be blocked
			alu_busy[i] = (i == LAST) ? hold_valid : 1'b0;
		end
	end

endmodule

// ==== rob.sv ====
////////////////////////////////////////
// reorder buffer
// circular buffer, allocates at tail,
// marks results from the cdb and retires
// completed entries from head in order
////////////////////////////////////////

`timescale 1ns/1ps

`include "ooo_defines.svh"

module rob
	import ooo_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  dispatch_t   dispatch [`WAYS],
	input  cdb_t        cdb [`WAYS],
	output rob_idx_t    dispatch_idx [`WAYS],
	output logic        stall,
	output rob_cnt_t    num_free,
	output commit_t     commit [`WAYS],
	output commit_cnt_t commit_count
);

	localparam int DEPTH = `ROB_DEPTH;

	// pointers and occupancy
	rob_idx_t         head_q;
	rob_idx_t         tail_q;
	rob_cnt_t         free_q;
	logic [DEPTH-1:0] done_q;

	// entry payload
	word_t     ent_data [DEPTH];
	dispatch_t ent_disp [DEPTH];

	// per-cycle bookkeeping
	logic [`WAYS-1:0] alloc_en;
	rob_cnt_t         alloc_cnt;
	commit_cnt_t      retire_cnt;
	rob_cnt_t         used;
	rob_idx_t         head_idx [`WAYS];

	////////////////////////////////////////
	// dispatch side
	////////////////////////////////////////

	always_comb begin
		alloc_cnt = '0;
		for (int i = 0; i < `WAYS; i++) begin
			// lane i lands at tail + i, wraps naturally
			dispatch_idx[i] = tail_q + rob_idx_t'(i);
			alloc_en[i]     = dispatch[i].valid & ~stall;
			alloc_cnt       = alloc_cnt + rob_cnt_t'(alloc_en[i]);
		end
	end

	////////////////////////////////////////
	// commit side
	////////////////////////////////////////

	always_comb begin
		logic run;
		run        = 1'b1;
		retire_cnt = '0;
		used       = rob_cnt_t'(DEPTH) - free_q;
		for (int i = 0; i < `WAYS; i++) begin
			head_idx[i] = head_q + rob_idx_t'(i);
			// stop at the first empty or unfinished entry
			run        = run & (rob_cnt_t'(i) < used) & done_q[head_idx[i]];
			retire_cnt = retire_cnt + commit_cnt_t'(run);
			commit[i]  = '{
				valid:     run,
				dest:      ent_disp[head_idx[i]].dest,
				reg_write: ent_disp[head_idx[i]].reg_write,
				pc:        ent_disp[head_idx[i]].pc,
				data:      ent_data[head_idx[i]]
			};
		end
	end

	assign commit_count = retire_cnt;
	assign num_free     = free_q;

	// back-pressure from free count after this cycle's retirement
	assign stall = (free_q + rob_cnt_t'(retire_cnt)) < rob_cnt_t'(`WAYS);

	////////////////////////////////////////
	// state update
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			free_q <= rob_cnt_t'(DEPTH);
			done_q <= '0;
		end else begin
			head_q <= head_q + rob_idx_t'(retire_cnt);
			tail_q <= tail_q + rob_idx_t'(alloc_cnt);
			free_q <= free_q + rob_cnt_t'(retire_cnt) - alloc_cnt;
			// new entries start incomplete
			for (int i = 0; i < `WAYS; i++) begin
				if (alloc_en[i]) begin
					done_q[dispatch_idx[i]] <= 1'b0;
				end
			end
			// completion from the bus
			for (int i = 0; i < `WAYS; i++) begin
				if (cdb[i].valid) begin
					done_q[cdb[i].rob_idx] <= 1'b1;
				end
			end
		end
	end

	// dispatch fields and result data
	always_ff @(posedge clock) begin
		for (int i = 0; i < `WAYS; i++) begin
			if (alloc_en[i]) begin
				ent_disp[dispatch_idx[i]] <= dispatch[i];
			end
		end
		for (int i = 0; i < `WAYS; i++) begin
			if (cdb[i].valid) begin
				ent_data[cdb[i].rob_idx] <= cdb[i].data;
			end
		end
	end

endmodule

// ==== arch_regfile.sv ====
////////////////////////////////////////
// architectural register file
// written by committing lanes, r0 is zero,
// one combinational read port
////////////////////////////////////////

`timescale 1ns/1ps

`include "ooo_defines.svh"

module arch_regfile
	import ooo_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	input  commit_t   commit [`WAYS],
	input  arch_reg_t rd_idx,
	output word_t     rd_data
);

	word_t regs [`NUM_REGS];

	// commit writes
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < `NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			// later lane overrides on the same dest
			for (int i = 0; i < `WAYS; i++) begin
				if (commit[i].valid && commit[i].reg_write && commit[i].dest != '0) begin
					regs[commit[i].dest] <= commit[i].data;
				end
			end
		end
	end

	// read port, r0 keeps its reset value
	assign rd_data = regs[rd_idx];

endmodule

// ==== ooo_backend.sv ====
////////////////////////////////////////
// out-of-order back end top
// cdb merge, reorder buffer and
// architectural register file
////////////////////////////////////////

`timescale 1ns/1ps

`include "ooo_defines.svh"

module ooo_backend
	import ooo_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  dispatch_t   dispatch [`WAYS],
	input  cdb_t        alu_result [`WAYS],
	input  cdb_t        load_result,
	input  arch_reg_t   rd_idx,
	output rob_idx_t    dispatch_idx [`WAYS],
	output logic        stall,
	output rob_cnt_t    num_free,
	output logic        alu_busy [`WAYS],
	output commit_t     commit [`WAYS],
	output commit_cnt_t commit_count,
	output word_t       rd_data
);

	// registered result bus
	cdb_t cdb_bus [`WAYS];

	////////////////////////////////////////
	// result broadcast
	////////////////////////////////////////

	cdb_merge i_cdb_merge (
		.clock       (clock),
		.rst_n       (rst_n),
		.alu_result  (alu_result),
		.load_result (load_result),
		.cdb         (cdb_bus),
		.alu_busy    (alu_busy)
	);

	////////////////////////////////////////
	// reorder buffer and retirement
	////////////////////////////////////////

	rob i_rob (
		.clock        (clock),
		.rst_n        (rst_n),
		.dispatch     (dispatch),
		.cdb          (cdb_bus),
		.dispatch_idx (dispatch_idx),
		.stall        (stall),
		.num_free     (num_free),
		.commit       (commit),
		.commit_count (commit_count)
	);

	// committed state
	arch_regfile i_arch_regfile (
		.clock   (clock),
		.rst_n   (rst_n),
		.commit  (commit),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

endmodule

// ==== tb_ooo_backend.sv ====
////////////////////////////////////////
// back end testbench
// lcg stimulus against a queue model of
// the rob, the bus hold and the regfile
////////////////////////////////////////

`timescale 1ns/1ps

`include "ooo_defines.svh"

module tb_ooo_backend
	import ooo_pkg::*;
();

	localparam int LAST = `WAYS - 1;

	// dut pins with inputs starting idle
	logic        clock;
	logic        rst_n = 1'b0;
	dispatch_t   dispatch [`WAYS] = '{default: '0};
	cdb_t        alu_result [`WAYS] = '{default: '0};
	cdb_t        load_result = '0;
	arch_reg_t   rd_idx = '0;
	rob_idx_t    dispatch_idx [`WAYS];
	logic        stall;
	rob_cnt_t    num_free;
	logic        alu_busy [`WAYS];
	commit_t     commit [`WAYS];
	commit_cnt_t commit_count;
	word_t       rd_data;

	// reference model
	commit_t     expect_q [$];
	cdb_t        pending [$];
	word_t       reg_model [`NUM_REGS] = '{default: '0};
	rob_idx_t    tail_model = '0;
	rob_idx_t    head_model = '0;
	logic        hold_model = 1'b0;
	rob_idx_t    held_idx = '0;
	// completion per rob entry and the indices now on the bus
	logic [`ROB_DEPTH-1:0] done_model = '0;
	rob_idx_t    bus_q [$];
	logic        stalled = 1'b0;
	logic [31:0] lcg_state = 32'h9665_8d7b;
	int          cycles = 0;

	// stimulus for the next rising edge
	dispatch_t   nxt_dispatch [`WAYS] = '{default: '0};
	cdb_t        nxt_alu [`WAYS] = '{default: '0};
	cdb_t        nxt_load = '0;
	arch_reg_t   nxt_rd = '0;
	// 0 idle, 1 full width, 2 random width
	int          dispatch_mode = 0;
	logic        results_on = 1'b0;
	logic        sweep_on = 1'b0;

	ooo_backend i_ooo_backend (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		dispatch    <= nxt_dispatch;
		alu_result  <= nxt_alu;
		load_result <= nxt_load;
		rd_idx      <= nxt_rd;
	end

	////////////////////////////////////////
	// error reporting and random numbers
	////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string sig, input logic [71:0] expected,
			input logic [71:0] actual);
		abort_run($sformatf("Fail at time %0t: %s expected %0h, actual %0h",
			$time, sig, expected, actual));
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// low bits of an lcg are weak
	function automatic int pick(input int n);
		return int'((next_rand() >> 8) % 32'(n));
	endfunction

	////////////////////////////////////////
	// per-cycle checks sampled at negedge
	////////////////////////////////////////

	task automatic check_outputs();
		int      lanes;
		int      ready;
		commit_t exp_c;
		logic    exp_stall;
		word_t   data;
		lanes = 0;
		// read port shows state before this cycle's commits
		assert (rd_data == reg_model[rd_idx])
			else report_mismatch("rd_data", 72'(reg_model[rd_idx]), 72'(rd_data));
		assert (num_free == rob_cnt_t'(`ROB_DEPTH - expect_q.size()))
			else report_mismatch("num_free", 72'(`ROB_DEPTH - expect_q.size()), 72'(num_free));
		// completed entries in a row from the head
		ready = 0;
		while (ready < `WAYS && ready < expect_q.size()
				&& done_model[head_model + rob_idx_t'(ready)]) begin
			ready++;
		end
		for (int i = 0; i < `WAYS; i++) begin
			if (commit[i].valid) begin
				assert (lanes == i && expect_q.size() > 0)
					else abort_run("commit lane valid above an idle lane or with nothing in flight");
				lanes++;
				exp_c = expect_q.pop_front();
				head_model = head_model + rob_idx_t'(1);
				assert (commit[i] == exp_c)
					else report_mismatch($sformatf("commit[%0d]", i), 72'(exp_c), 72'(commit[i]));
				// r0 never written
				if (exp_c.reg_write && exp_c.dest != '0) begin
					reg_model[exp_c.dest] = exp_c.data;
				end
			end
		end
		assert (lanes == ready)
			else report_mismatch("commit lanes", 72'(ready), 72'(lanes));
		assert (commit_count == commit_cnt_t'(lanes))
			else report_mismatch("commit_count", 72'(lanes), 72'(commit_count));
		// free count once this cycle's commits leave
		exp_stall = (`ROB_DEPTH - expect_q.size()) < `WAYS;
		stalled   = exp_stall;
		assert (stall == exp_stall)
			else report_mismatch("stall", 72'(exp_stall), 72'(stall));
		for (int i = 0; i < `WAYS; i++) begin
			assert (alu_busy[i] == (i == LAST && hold_model))
				else report_mismatch($sformatf("alu_busy[%0d]", i),
					72'(i == LAST && hold_model), 72'(alu_busy[i]));
			assert (dispatch_idx[i] == tail_model + rob_idx_t'(i))
				else report_mismatch($sformatf("dispatch_idx[%0d]", i),
					72'(tail_model + rob_idx_t'(i)), 72'(dispatch_idx[i]));
		end
		// lanes on the pins go in at the coming edge
		for (int i = 0; i < `WAYS; i++) begin
			if (dispatch[i].valid && !exp_stall) begin
				data = next_rand();
				expect_q.push_back(commit_t'{1'b1, dispatch[i].dest, dispatch[i].reg_write,
					dispatch[i].pc, data});
				pending.push_back(cdb_t'{1'b1, tail_model, data});
				done_model[tail_model] = 1'b0;
				tail_model = tail_model + rob_idx_t'(1);
			end
		end
		// bus lanes of this cycle mark their entries at the coming edge
		foreach (bus_q[j]) begin
			done_model[bus_q[j]] = 1'b1;
		end
		bus_q.delete();
		// results on the pins reach the bus at the coming edge
		for (int i = 0; i < LAST; i++) begin
			if (alu_result[i].valid) begin
				bus_q.push_back(alu_result[i].rob_idx);
			end
		end
		// last lane goes to the load first, then the held result
		if (load_result.valid) begin
			bus_q.push_back(load_result.rob_idx);
		end else if (hold_model) begin
			bus_q.push_back(held_idx);
		end else if (alu_result[LAST].valid) begin
			bus_q.push_back(alu_result[LAST].rob_idx);
		end
		if (!hold_model && load_result.valid && alu_result[LAST].valid) begin
			held_idx = alu_result[LAST].rob_idx;
		end
		// hold fills when a load bumps the last way and drains on a load-free cycle
		hold_model = hold_model ? load_result.valid
			: (load_result.valid & alu_result[LAST].valid);
	endtask

	task automatic choose_inputs();
		int n;
		int k;
		n = (dispatch_mode == 1) ? `WAYS : ((dispatch_mode == 2) ? pick(`WAYS + 1) : 0);
		for (int i = 0; i < `WAYS; i++) begin
			nxt_dispatch[i] = '0;
			nxt_alu[i]      = '0;
			if (i < n) begin
				nxt_dispatch[i].valid     = 1'b1;
				// r0 shows up often as a destination
				nxt_dispatch[i].dest      = (pick(8) == 0) ? '0 : arch_reg_t'(pick(`NUM_REGS));
				nxt_dispatch[i].reg_write = pick(4) != 0;
				nxt_dispatch[i].pc        = next_rand() & 32'hffff_fffc;
			end
			// last way held back while the hold is full
			if (results_on && pending.size() > 0 && pick(2) == 1 && !(i == LAST && hold_model)) begin
				k          = pick(pending.size());
				nxt_alu[i] = pending[k];
				pending.delete(k);
			end
		end
		nxt_load = '0;
		if (results_on && pending.size() > 0 && pick(2) == 1) begin
			k        = pick(pending.size());
			nxt_load = pending[k];
			pending.delete(k);
		end
		if (!sweep_on) begin
			nxt_rd = arch_reg_t'(pick(`NUM_REGS));
		end
	endtask

	task automatic step();
		@(negedge clock);
		check_outputs();
		choose_inputs();
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		@(posedge clock);
		// reset state matches the empty model
		@(negedge clock);
		check_outputs();
		@(posedge clock);
		rst_n <= 1'b1;
		// fill the rob with no results coming back
		dispatch_mode = 1;
		while (!stalled) begin
			step();
		end
		repeat (6) begin
			step();
		end
		// random traffic with results out of order
		results_on    = 1'b1;
		dispatch_mode = 2;
		repeat (400) begin
			step();
		end
		dispatch_mode = 0;
		while (expect_q.size() > 0 || pending.size() > 0 || hold_model) begin
			step();
		end
		// read back every register
		sweep_on = 1'b1;
		for (int r = 0; r < `NUM_REGS; r++) begin
			nxt_rd = arch_reg_t'(r);
			step();
		end
		step();
		$display("Simulation finished: PASS");
		$finish;
	end

	assert property (@(posedge clock) disable iff (!rst_n) commit_count <= commit_cnt_t'(`WAYS))
		else abort_run("commit_count is above the commit width");

	// run limit of about four times the stimulus
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > 2000) begin
			abort_run("Timeout: the run did not finish within 2000 cycles");
		end
	end

endmodule

// ==== build.f ====
+incdir+.
ooo_pkg.sv
cdb_merge.sv
rob.sv
arch_regfile.sv
ooo_backend.sv
tb_ooo_backend.sv

// ==== Makefile ====
# Verilator build and run of the back end testbench

.PHONY: run clean

run: obj_dir/Vtb_ooo_backend
	@out="$$(./obj_dir/Vtb_ooo_backend)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

obj_dir/Vtb_ooo_backend: build.f ooo_defines.svh $(wildcard *.sv)
	verilator --binary --timing --assert --top-module tb_ooo_backend -f build.f

clean:
	rm -rf obj_dir
